// File: logic/div_pkg.sv
`default_nettype none

package div_pkg;

  // ******************************
  // operation encoding
  // ******************************

  // bit 0 signed, bit 1 remainder
  typedef enum logic [1:0] {
    DIVU = 2'b00,
    DIV  = 2'b01,
    REMU = 2'b10,
    REM  = 2'b11
  } div_op_e;

  // ******************************
  // stage to stage bundles
  // ******************************

  typedef struct packed {
    logic is_signed;
    logic want_rem;
    // operand signs differ
    logic neg_quot;
    // dividend negative
    logic neg_rem;
  } div_ctrl_t;

  typedef struct packed {
    logic div_zero;
    logic rem_restore;
  } div_stat_t;

endpackage

`default_nettype wire

// File: logic/cla_64.sv
`timescale 1ns/100ps
`default_nettype none

module cla_64 #(
  parameter int WIDTH = 64
) (
  input  wire [WIDTH-1:0]  a,
  input  wire [WIDTH-1:0]  b,
  input  wire              cin,
  output logic [WIDTH-1:0] sum,
  output logic             cout
);

  // odd widths padded up to whole groups of 4
  localparam int NG = (WIDTH + 3) / 4;
  localparam int PW = NG * 4;

  logic [PW-1:0] ap;
  logic [PW-1:0] bp;
  logic [PW-1:0] g;
  logic [PW-1:0] p;
  wire  [PW:0]   c;

  assign ap = PW'(a);
  assign bp = PW'(b);

  // per bit generate and propagate
  assign g = ap & bp;
  assign p = ap ^ bp;

  assign c[0] = cin;

  for (genvar k = 0; k < NG; k++) begin : g_grp
    localparam int B = 4 * k;

    logic gg;
    logic pg;

    // lookahead inside the group
    assign c[B+1] = g[B] | (p[B] & c[B]);
    assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & c[B]);
    assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
                  | (p[B+2] & p[B+1] & p[B] & c[B]);

    // group terms, carry ripples group to group
    assign gg = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
              | (p[B+3] & p[B+2] & p[B+1] & g[B]);
    assign pg = &p[B+3:B];

    assign c[B+4] = gg | (pg & c[B]);
  end

  assign sum  = p[WIDTH-1:0] ^ c[WIDTH-1:0];
  assign cout = c[WIDTH];

endmodule

`default_nettype wire

// File: logic/div_op_decode.sv
`timescale 1ns/100ps
`default_nettype none

module div_op_decode import div_pkg::*; #(
  parameter int WIDTH = 64
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire [WIDTH-1:0]  dividend,
  input  wire [WIDTH-1:0]  divisor,
  input  wire div_op_e     op,
  input  wire              accept,
  output logic [WIDTH-1:0] dvd_mag,
  output logic [WIDTH-1:0] dvs_mag,
  output div_ctrl_t        ctrl,
  output logic             start
);

  logic is_signed;
  logic want_rem;
  logic dvd_neg;
  logic dvs_neg;

  assign is_signed = (op == DIV) || (op == REM);
  assign want_rem  = (op == REMU) || (op == REM);
  assign dvd_neg   = is_signed & dividend[WIDTH-1];
  assign dvs_neg   = is_signed & divisor[WIDTH-1];

  // magnitudes of the operands, two's complement for negative signed ones
  always_ff @(posedge clk) begin
    if (accept) begin
      dvd_mag <= dvd_neg ? (~dividend + 1'b1) : dividend;
      dvs_mag <= dvs_neg ? (~divisor + 1'b1) : divisor;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl  <= '0;
      start <= 1'b0;
    end else begin
      start <= accept;
      if (accept) begin
        ctrl.is_signed <= is_signed;
        ctrl.want_rem  <= want_rem;
        ctrl.neg_quot  <= dvd_neg ^ dvs_neg;
        ctrl.neg_rem   <= dvd_neg;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/div_iter_core.sv
`timescale 1ns/100ps
`default_nettype none

module div_iter_core import div_pkg::*; #(
  parameter int WIDTH = 64
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              flush,
  input  wire              start,
  input  wire [WIDTH-1:0]  dvd_mag,
  input  wire [WIDTH-1:0]  dvs_mag,
  input  wire div_ctrl_t   ctrl_in,
  output logic             busy,
  output logic             done,
  output logic [WIDTH-1:0] quot,
  output logic [WIDTH-1:0] prem,
  output div_stat_t        stat,
  output div_ctrl_t        ctrl_out
);

  localparam int CW = $clog2(WIDTH + 1);

  // upper WIDTH+1 bits partial remainder, lower WIDTH bits dividend / quotient
  logic [2*WIDTH:0] pq;
  logic [WIDTH:0]   dvs_pos;
  logic [WIDTH:0]   dvs_neg;
  logic [CW-1:0]    cnt;
  logic             div_zero;

  logic [WIDTH:0]   shifted;
  logic [WIDTH:0]   addend;
  logic [WIDTH:0]   sum;
  logic             qbit;

  // ******************************
  // one non-restoring step
  // ******************************

  // 2r plus next dividend bit
  assign shifted = pq[2*WIDTH-1:WIDTH-1];

  // negative remainder adds, otherwise subtract
  assign addend = pq[2*WIDTH] ? dvs_pos : dvs_neg;

  cla_64 #(
    .WIDTH (WIDTH + 1)
  ) i_cla (
    .a    (shifted),
    .b    (addend),
    .cin  (1'b0),
    .sum  (sum),
    .cout ()
  );

  assign qbit = ~sum[WIDTH];

  // ******************************
  // datapath registers
  // ******************************

  always_ff @(posedge clk) begin
    if (start && !flush) begin
      pq      <= {{(WIDTH + 1){1'b0}}, dvd_mag};
      dvs_pos <= {1'b0, dvs_mag};
      dvs_neg <= ~{1'b0, dvs_mag} + 1'b1;
    end else if (busy) begin
      pq <= {sum, pq[WIDTH-2:0], qbit};
    end
  end

  // ******************************
  // sequencing
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      cnt      <= '0;
      div_zero <= 1'b0;
      ctrl_out <= '0;
    end else if (flush) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else if (start) begin
      busy     <= 1'b1;
      done     <= 1'b0;
      cnt      <= CW'(WIDTH);
      div_zero <= (dvs_mag == '0);
      ctrl_out <= ctrl_in;
    end else if (busy) begin
      cnt <= cnt - 1'b1;
      // last iteration
      if (cnt == CW'(1)) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end else begin
      done <= 1'b0;
    end
  end

  assign quot = pq[WIDTH-1:0];
  assign prem = pq[2*WIDTH-1:WIDTH];

  // sign of final remainder
  assign stat = '{div_zero: div_zero, rem_restore: pq[2*WIDTH]};

endmodule

`default_nettype wire

// File: logic/div_result_fix.sv
`timescale 1ns/100ps
`default_nettype none

module div_result_fix import div_pkg::*; #(
  parameter int WIDTH = 64
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              flush,
  input  wire              done,
  input  wire [WIDTH-1:0]  dvd_orig,
  input  wire [WIDTH-1:0]  dvs_mag,
  input  wire [WIDTH-1:0]  quot,
  input  wire [WIDTH-1:0]  prem,
  input  wire div_stat_t   stat,
  input  wire div_ctrl_t   ctrl,
  output logic             out_valid,
  output logic [WIDTH-1:0] result
);

  logic [WIDTH-1:0] rem_restored;
  logic [WIDTH-1:0] rem_mag;
  logic [WIDTH-1:0] sel_mag;
  logic             sel_neg;
  logic [WIDTH-1:0] fixed;

  // negative remainder plus divisor, result fits WIDTH bits
  cla_64 #(
    .WIDTH (WIDTH)
  ) i_cla_restore (
    .a    (prem),
    .b    (dvs_mag),
    .cin  (1'b0),
    .sum  (rem_restored),
    .cout ()
  );

  assign rem_mag = stat.rem_restore ? rem_restored : prem;
  assign sel_mag = ctrl.want_rem ? rem_mag : quot;
  assign sel_neg = ctrl.is_signed & (ctrl.want_rem ? ctrl.neg_rem : ctrl.neg_quot);

  // x/0 gives all ones, x%0 gives x
  always_comb begin
    if (stat.div_zero) begin
      fixed = ctrl.want_rem ? dvd_orig : '1;
    end else if (sel_neg) begin
      fixed = ~sel_mag + 1'b1;
    end else begin
      fixed = sel_mag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      result    <= '0;
    end else begin
      out_valid <= done && !flush;
      if (done && !flush) begin
        result <= fixed;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/div_unit.sv
`timescale 1ns/100ps
`default_nettype none

module div_unit import div_pkg::*; #(
  parameter int WIDTH = 64
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire [WIDTH-1:0]  dividend,
  input  wire [WIDTH-1:0]  divisor,
  input  wire div_op_e     op,
  input  wire              in_valid,
  input  wire              flush,
  output logic             in_ready,
  output logic             out_valid,
  output logic [WIDTH-1:0] result
);

  logic             accept;
  logic             start;
  logic             busy;
  logic             done;
  logic [WIDTH-1:0] dvd_mag;
  logic [WIDTH-1:0] dvs_mag;
  logic [WIDTH-1:0] dvd_orig;
  logic [WIDTH-1:0] quot;
  logic [WIDTH-1:0] prem;
  div_ctrl_t        dec_ctrl;
  div_ctrl_t        exe_ctrl;
  div_stat_t        exe_stat;

  // low from acceptance until out_valid
  assign in_ready = !(busy || start || done);
  assign accept   = in_valid && in_ready && !flush;

  // dividend as given, for the divide by zero remainder
  always_ff @(posedge clk) begin
    if (accept) begin
      dvd_orig <= dividend;
    end
  end

  // ******************************
  // decode / execute / result
  // ******************************

  div_op_decode #(
    .WIDTH (WIDTH)
  ) i_div_op_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .dividend (dividend),
    .divisor  (divisor),
    .op       (op),
    .accept   (accept),
    .dvd_mag  (dvd_mag),
    .dvs_mag  (dvs_mag),
    .ctrl     (dec_ctrl),
    .start    (start)
  );

  div_iter_core #(
    .WIDTH (WIDTH)
  ) i_div_iter_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (flush),
    .start    (start),
    .dvd_mag  (dvd_mag),
    .dvs_mag  (dvs_mag),
    .ctrl_in  (dec_ctrl),
    .busy     (busy),
    .done     (done),
    .quot     (quot),
    .prem     (prem),
    .stat     (exe_stat),
    .ctrl_out (exe_ctrl)
  );

  div_result_fix #(
    .WIDTH (WIDTH)
  ) i_div_result_fix (
    .clk       (clk),
    .rst_n     (rst_n),
    .flush     (flush),
    .done      (done),
    .dvd_orig  (dvd_orig),
    .dvs_mag   (dvs_mag),
    .quot      (quot),
    .prem      (prem),
    .stat      (exe_stat),
    .ctrl      (exe_ctrl),
    .out_valid (out_valid),
    .result    (result)
  );

endmodule

`default_nettype wire

// File: dv/div_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module div_unit_tb import div_pkg::*; ();

  localparam int WIDTH = 64;
  localparam int LATENCY = WIDTH + 2;
  // ready and flush tests each weigh about three operations
  localparam int N_OPS = 42;
  localparam int MAX_CYCLES = N_OPS * 70 + 200;
  localparam logic [WIDTH-1:0] MIN_VAL = {1'b1, {(WIDTH-1){1'b0}}};

  logic             clk;
  logic             rst_n;
  logic [WIDTH-1:0] dividend;
  logic [WIDTH-1:0] divisor;
  div_op_e          op;
  logic             in_valid;
  logic             flush;
  logic             in_ready;
  logic             out_valid;
  logic [WIDTH-1:0] result;

  integer seed;
  int     errors;
  int     checks;
  int     cycles = 0;

  div_unit #(
    .WIDTH (WIDTH)
  ) i_div_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .dividend  (dividend),
    .divisor   (divisor),
    .op        (op),
    .in_valid  (in_valid),
    .flush     (flush),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .result    (result)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ******************************
  // checking and reference model
  // ******************************

  task automatic check(input string name, input logic [WIDTH-1:0] got,
                       input logic [WIDTH-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // RISC-V rules with bit 0 of op signed and bit 1 remainder
  function automatic logic [WIDTH-1:0] model(input div_op_e o, input logic [WIDTH-1:0] a,
                                             input logic [WIDTH-1:0] b);
    logic sgn;
    logic rem;
    logic [WIDTH-1:0] r;
    sgn = o[0];
    rem = o[1];
    if (b == '0)
      r = rem ? a : '1;
    else if (sgn && a == MIN_VAL && b == '1)
      r = rem ? '0 : MIN_VAL;
    else if (sgn && rem)
      r = $signed(a) % $signed(b);
    else if (sgn)
      r = $signed(a) / $signed(b);
    else if (rem)
      r = a % b;
    else
      r = a / b;
    return r;
  endfunction

  // ******************************
  // driving helpers
  // ******************************

  // returns on the acceptance edge
  task automatic issue(input div_op_e o, input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    @(posedge clk);
    op       <= o;
    dividend <= a;
    divisor  <= b;
    in_valid <= 1'b1;
    do
      @(negedge clk);
    while (!in_ready);
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_result(output int lat);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      @(negedge clk);
    end while (!out_valid && lat < LATENCY + 10);
  endtask

  task automatic run_op(input div_op_e o, input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
    int lat;
    issue(o, a, b);
    wait_result(lat);
    if (!out_valid) begin
      errors++;
      $display("no out_valid after a %s request", o.name());
    end else begin
      check("latency", lat, LATENCY);
      check($sformatf("result %s", o.name()), result, model(o, a, b));
    end
  endtask

  // narrow operands get a random right shift so the quotient is not tiny
  task automatic rand_operand(input logic narrow, output logic [WIDTH-1:0] v);
    logic [5:0] sh;
    v  = {$random(seed), $random(seed)};
    sh = $random(seed);
    if (narrow)
      v = v >> sh;
  endtask

  // ******************************
  // directed tests
  // ******************************

  task automatic reset_values();
    @(negedge clk);
    check("in_ready", in_ready, 1);
    check("out_valid", out_valid, 0);
    check("result", result, 0);
  endtask

  task automatic unsigned_ops();
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    run_op(DIVU, 100, 7);
    run_op(REMU, 100, 7);
    run_op(DIVU, '1, 3);
    run_op(REMU, '1, 3);
    run_op(DIVU, 5, 10);
    run_op(REMU, 5, 10);
    run_op(DIVU, MIN_VAL, '1);
    run_op(REMU, MIN_VAL, '1);
    repeat (4) begin
      rand_operand(1'b0, a);
      rand_operand(1'b1, b);
      run_op(DIVU, a, b);
      run_op(REMU, a, b);
    end
  endtask

  task automatic signed_ops();
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    for (int s = 0; s < 4; s++) begin
      a = s[0] ? -64'sd17 : 64'sd17;
      b = s[1] ? -64'sd5 : 64'sd5;
      run_op(DIV, a, b);
      run_op(REM, a, b);
    end
    repeat (2) begin
      rand_operand(1'b0, a);
      rand_operand(1'b1, b);
      run_op(DIV, a, b);
      run_op(REM, a, b);
    end
  endtask

  task automatic special_cases();
    for (int i = 0; i < 4; i++)
      run_op(div_op_e'(i), 64'h8000_0000_0000_0123, '0);
    run_op(DIV, MIN_VAL, '1);
    run_op(REM, MIN_VAL, '1);
  endtask

  task automatic ready_hold();
    int pulses;
    logic [WIDTH-1:0] exp;
    exp = model(DIVU, 1000, 9);
    issue(DIVU, 1000, 9);
    // competing request while busy, held until out_valid
    @(posedge clk);
    op       <= REMU;
    dividend <= 64'd77;
    divisor  <= 64'd4;
    in_valid <= 1'b1;
    repeat (LATENCY - 1) begin
      @(negedge clk);
      if (in_ready) begin
        errors++;
        $display("in_ready went high while an operation was in flight");
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
    pulses = 0;
    repeat (100) begin
      @(negedge clk);
      if (out_valid) begin
        pulses++;
        check("result DIVU", result, exp);
      end
    end
    check("out_valid pulses", pulses, 1);
  endtask

  task automatic flush_abort();
    logic seen;
    issue(DIV, -64'sd1000, 64'sd7);
    repeat (20) @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(negedge clk);
    check("in_ready", in_ready, 1);
    seen = 1'b0;
    repeat (70) begin
      @(negedge clk);
      if (out_valid)
        seen = 1'b1;
    end
    if (seen) begin
      errors++;
      $display("out_valid was raised for a flushed operation");
    end
    run_op(REM, -64'sd1000, 64'sd7);
  endtask

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    dividend = '0;
    divisor  = '0;
    op       = DIVU;
    in_valid = 1'b0;
    flush    = 1'b0;
    seed     = 32'he487a901;
    errors   = 0;
    checks   = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    reset_values();
    unsigned_ops();
    signed_ops();
    special_cases();
    ready_hold();
    flush_abort();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
logic/div_pkg.sv
logic/cla_64.sv
logic/div_op_decode.sv
logic/div_iter_core.sv
logic/div_result_fix.sv
logic/div_unit.sv
dv/div_unit_tb.sv
